// File: src/stepper_pkg.sv
package stepper_pkg;

  // Axis and buffer sizing
  localparam int motor_count = 2;
  localparam int buffer_slots = 2;
  localparam int buffer_index_bits = 1;

  // Header, duration, then increment and increment-increment per axis
  localparam int move_words = 2 + 2 * motor_count;

  typedef logic [63:0] word_t;
  typedef logic [motor_count-1:0] axis_vec_t;
  typedef logic [31:0] duration_t;
  typedef logic signed [63:0] rate_t;
  typedef logic signed [31:0] step_count_t;
  typedef logic [7:0] divisor_t;
  typedef logic [7:0] header_t;

  // Command codes in bits 63:56 of a header word
  localparam header_t cmd_coordinated_step = 8'h01;
  localparam header_t cmd_motor_enable = 8'h0a;
  localparam header_t cmd_motor_brake = 8'h0b;
  localparam header_t cmd_clk_divisor = 8'h20;
  localparam header_t cmd_api_version = 8'hfe;

  // API version returned on request
  localparam logic [7:0] version_major = 8'd1;
  localparam logic [7:0] version_minor = 8'd2;
  localparam logic [7:0] version_patch = 8'd0;
  localparam logic [7:0] version_devel = 8'd1;

  // About 400 kHz of DDA ticks from a 16 MHz clock
  localparam divisor_t default_divisor = 8'd40;

  typedef enum logic [1:0] {
    seq_idle,
    seq_loading,
    seq_executing
  } seq_state_t;

endpackage

// File: src/dda_axis.sv
`timescale 1ns/1ps

module dda_axis (
  input  logic                     CLK,
  input  logic                     resetn,
  input  logic                     dda_tick,
  input  logic                     load_move,
  input  logic                     executing,
  input  stepper_pkg::rate_t       rate,
  input  stepper_pkg::rate_t       accel,
  input  logic                     dir_bit,
  output logic                     step_bit,
  output stepper_pkg::step_count_t step_count
);
  import stepper_pkg::*;

  rate_t velocity;
  rate_t acceleration;
  logic [$bits(rate_t)-1:0] phase;
  logic [$bits(rate_t):0] phase_sum;
  logic advance;

  assign advance = dda_tick & executing;

  // Unsigned add with the carry out as the step
  assign phase_sum = {1'b0, phase} + {1'b0, velocity};
  assign step_bit = advance & phase_sum[$bits(rate_t)];

  always_ff @(posedge CLK) begin
    if (resetn) begin
      velocity <= '0;
      acceleration <= '0;
      phase <= '0;
      step_count <= '0;
    end else begin
      // Phase carries over from one move to the next
      if (load_move) begin
        velocity <= rate;
        acceleration <= accel;
      end else if (advance) begin
        phase <= phase_sum[$bits(rate_t)-1:0];
        velocity <= velocity + acceleration;
      end
      if (step_bit) begin
        step_count <= dir_bit ? step_count + 1'b1 : step_count - 1'b1;
      end
    end
  end

endmodule

// File: src/move_buffer.sv
`timescale 1ns/1ps

module move_buffer (
  input  logic                                    CLK,
  input  logic                                    resetn,
  input  logic [stepper_pkg::buffer_index_bits-1:0] wr_slot,
  input  stepper_pkg::axis_vec_t                  wr_dir,
  input  stepper_pkg::duration_t                  wr_duration,
  input  stepper_pkg::rate_t                      wr_rate,
  input  stepper_pkg::rate_t                      wr_accel,
  input  logic [stepper_pkg::move_words-1:0]      wr_field_en,
  input  logic                                    wr_commit,
  input  logic [stepper_pkg::buffer_index_bits-1:0] rd_slot,
  output logic [stepper_pkg::buffer_slots-1:0]    slot_ready,
  output stepper_pkg::axis_vec_t                  rd_dir,
  output stepper_pkg::duration_t                  rd_duration,
  output stepper_pkg::rate_t                      rd_rate [stepper_pkg::motor_count],
  output stepper_pkg::rate_t                      rd_accel [stepper_pkg::motor_count]
);
  import stepper_pkg::*;

  axis_vec_t dir_mem [buffer_slots];
  duration_t duration_mem [buffer_slots];
  rate_t rate_mem [buffer_slots][motor_count];
  rate_t accel_mem [buffer_slots][motor_count];

  // Field 0 dir, 1 duration, then rate and accel pairs per axis
  always_ff @(posedge CLK) begin
    if (wr_field_en[0]) begin
      dir_mem[wr_slot] <= wr_dir;
    end
    if (wr_field_en[1]) begin
      duration_mem[wr_slot] <= wr_duration;
    end
    for (int n = 0; n < motor_count; n++) begin
      if (wr_field_en[2 + 2 * n]) begin
        rate_mem[wr_slot][n] <= wr_rate;
      end
      if (wr_field_en[3 + 2 * n]) begin
        accel_mem[wr_slot][n] <= wr_accel;
      end
    end
  end

  // Slot is full while its ready toggle differs from the consumed toggle
  always_ff @(posedge CLK) begin
    if (resetn) begin
      slot_ready <= '0;
    end else if (wr_commit) begin
      slot_ready[wr_slot] <= ~slot_ready[wr_slot];
    end
  end

  assign rd_dir = dir_mem[rd_slot];
  assign rd_duration = duration_mem[rd_slot];

  always_comb begin
    for (int n = 0; n < motor_count; n++) begin
      rd_rate[n] = rate_mem[rd_slot][n];
      rd_accel[n] = accel_mem[rd_slot][n];
    end
  end

endmodule

// File: src/move_sequencer.sv
`timescale 1ns/1ps

module move_sequencer (
  input  logic                                    CLK,
  input  logic                                    resetn,
  input  stepper_pkg::divisor_t                   divisor,
  input  logic [stepper_pkg::buffer_slots-1:0]    slot_ready,
  input  stepper_pkg::duration_t                  rd_duration,
  output logic [stepper_pkg::buffer_index_bits-1:0] rd_slot,
  output logic                                    dda_tick,
  output logic                                    load_move,
  output logic                                    executing,
  output logic                                    move_done,
  output logic                                    buffer_dtr
);
  import stepper_pkg::*;

  divisor_t tick_div;
  seq_state_t state;
  duration_t ticks_left;
  logic [buffer_slots-1:0] consumed;
  logic [buffer_slots-1:0] slot_full;
  logic [buffer_index_bits-1:0] next_slot;
  logic final_tick;

  assign slot_full = slot_ready ^ consumed;
  assign next_slot = rd_slot + 1'b1;

  // Writes go in order, so the write slot is empty unless all are full
  assign buffer_dtr = ~&slot_full;

  assign load_move = (state == seq_loading);
  assign executing = (state == seq_executing);

  // Zero duration also ends on its first tick
  assign final_tick = executing & dda_tick & (ticks_left <= duration_t'(1));
  assign move_done = final_tick;

  // One tick every divisor+1 clocks
  always_ff @(posedge CLK) begin
    if (resetn) begin
      tick_div <= '0;
      dda_tick <= 1'b0;
    end else if (tick_div >= divisor) begin
      tick_div <= '0;
      dda_tick <= 1'b1;
    end else begin
      tick_div <= tick_div + 1'b1;
      dda_tick <= 1'b0;
    end
  end

  always_ff @(posedge CLK) begin
    if (resetn) begin
      state <= seq_idle;
      rd_slot <= '0;
      consumed <= '0;
      ticks_left <= '0;
    end else begin
      case (state)
        seq_idle: begin
          if (slot_full[rd_slot]) begin
            state <= seq_loading;
          end
        end
        seq_loading: begin
          ticks_left <= rd_duration;
          state <= seq_executing;
        end
        seq_executing: begin
          if (dda_tick) begin
            ticks_left <= ticks_left - 1'b1;
          end
          if (final_tick) begin
            consumed[rd_slot] <= ~consumed[rd_slot];
            rd_slot <= next_slot;
            // Queued move goes straight to loading
            state <= slot_full[next_slot] ? seq_loading : seq_idle;
          end
        end
        default: state <= seq_idle;
      endcase
    end
  end

endmodule

// File: src/command_decoder.sv
`timescale 1ns/1ps

module command_decoder (
  input  logic                                    CLK,
  input  logic                                    resetn,
  input  stepper_pkg::word_t                      word_in,
  input  logic                                    word_strobe,
  input  stepper_pkg::step_count_t                step_counts [stepper_pkg::motor_count],
  input  logic                                    buffer_dtr,
  output logic [stepper_pkg::buffer_index_bits-1:0] wr_slot,
  output stepper_pkg::axis_vec_t                  wr_dir,
  output stepper_pkg::duration_t                  wr_duration,
  output stepper_pkg::rate_t                      wr_rate,
  output stepper_pkg::rate_t                      wr_accel,
  output logic [stepper_pkg::move_words-1:0]      wr_field_en,
  output logic                                    wr_commit,
  output stepper_pkg::divisor_t                   divisor,
  output stepper_pkg::axis_vec_t                  enable,
  output stepper_pkg::axis_vec_t                  brake,
  output stepper_pkg::word_t                      reply_word
);
  import stepper_pkg::*;

  localparam int count_bits = $clog2(move_words);

  logic [1:0] strobe_sync;
  logic strobe_prev;
  logic word_accept;
  header_t message_header;
  header_t new_header;
  logic [count_bits-1:0] word_count;
  logic in_move;
  logic last_word;
  logic [buffer_index_bits-1:0] write_index;
  logic [buffer_index_bits-1:0] move_slot;
  logic overwrite;
  step_count_t snapshot [motor_count];

  // Sign extend a step count into a reply word
  function automatic word_t extend_count(input step_count_t count);
    return {{($bits(word_t) - $bits(step_count_t)){count[$bits(step_count_t)-1]}}, count};
  endfunction

  assign new_header = word_in[63:56];
  assign word_accept = strobe_sync[1] & ~strobe_prev;
  assign in_move = (message_header == cmd_coordinated_step);
  assign last_word = (word_count == count_bits'(move_words - 1));

  // A header that finds the buffer full replaces the pending move
  assign wr_slot = in_move ? move_slot
                           : (buffer_dtr ? write_index : write_index - 1'b1);
  assign wr_dir = word_in[motor_count-1:0];
  assign wr_duration = word_in[$bits(duration_t)-1:0];
  assign wr_rate = word_in;
  assign wr_accel = word_in;

  // Word index of a move equals its field index in the buffer
  always_comb begin
    wr_field_en = '0;
    if (word_accept) begin
      if (in_move) begin
        wr_field_en[word_count] = 1'b1;
      end else if (new_header == cmd_coordinated_step) begin
        wr_field_en[0] = 1'b1;
      end
    end
  end

  assign wr_commit = word_accept & in_move & last_word & ~overwrite;

  // Strobe synchronizer and edge detect
  always_ff @(posedge CLK) begin
    if (resetn) begin
      strobe_sync <= 2'b00;
      strobe_prev <= 1'b0;
    end else begin
      strobe_sync <= {strobe_sync[0], word_strobe};
      strobe_prev <= strobe_sync[1];
    end
  end

  // Step counts are frozen when the move header arrives
  always_ff @(posedge CLK) begin
    if (word_accept && !in_move && new_header == cmd_coordinated_step) begin
      for (int n = 0; n < motor_count; n++) begin
        snapshot[n] <= step_counts[n];
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (resetn) begin
      message_header <= '0;
      word_count <= '0;
      write_index <= '0;
      move_slot <= '0;
      overwrite <= 1'b0;
      enable <= '0;
      brake <= '0;
      divisor <= default_divisor;
      reply_word <= '0;
    end else if (word_accept) begin
      reply_word <= '0;
      if (!in_move) begin
        message_header <= new_header;
        word_count <= count_bits'(1);
        case (new_header)
          cmd_coordinated_step: begin
            move_slot <= wr_slot;
            overwrite <= ~buffer_dtr;
          end
          cmd_motor_enable: enable <= word_in[motor_count-1:0];
          cmd_motor_brake: brake <= word_in[motor_count-1:0];
          cmd_clk_divisor: divisor <= word_in[$bits(divisor_t)-1:0];
          cmd_api_version: begin
            reply_word <= {32'd0, version_devel, version_major, version_minor, version_patch};
          end
          default: reply_word <= '0;
        endcase
      end else begin
        word_count <= word_count + 1'b1;
        // Duration word answers with axis 0
        if (word_count == count_bits'(1)) begin
          reply_word <= extend_count(snapshot[0]);
        end
        // Increment-increment of axis n answers with axis n+1
        for (int n = 0; n < motor_count - 1; n++) begin
          if (word_count == count_bits'(3 + 2 * n)) begin
            reply_word <= extend_count(snapshot[n+1]);
          end
        end
        if (last_word) begin
          message_header <= '0;
          word_count <= '0;
          if (!overwrite) begin
            write_index <= write_index + 1'b1;
          end
        end
      end
    end
  end

endmodule

// File: src/stepper_ctrl_top.sv
`timescale 1ns/1ps

module stepper_ctrl_top (
  input  logic                   CLK,
  input  logic                   resetn,
  input  stepper_pkg::word_t     word_in,
  input  logic                   word_strobe,
  output stepper_pkg::word_t     reply_word,
  output logic                   buffer_dtr,
  output logic                   move_done,
  output stepper_pkg::axis_vec_t step,
  output stepper_pkg::axis_vec_t dir,
  output stepper_pkg::axis_vec_t enable,
  output stepper_pkg::axis_vec_t brake
);
  import stepper_pkg::*;

  step_count_t step_counts [motor_count];

  // Decoder to buffer
  logic [buffer_index_bits-1:0] wr_slot;
  axis_vec_t wr_dir;
  duration_t wr_duration;
  rate_t wr_rate;
  rate_t wr_accel;
  logic [move_words-1:0] wr_field_en;
  logic wr_commit;
  divisor_t divisor;

  // Buffer and sequencer
  logic [buffer_slots-1:0] slot_ready;
  logic [buffer_index_bits-1:0] rd_slot;
  duration_t rd_duration;
  rate_t rd_rate [motor_count];
  rate_t rd_accel [motor_count];
  logic dda_tick;
  logic load_move;
  logic executing;

  command_decoder u_decoder (
    .CLK         (CLK),
    .resetn      (resetn),
    .word_in     (word_in),
    .word_strobe (word_strobe),
    .step_counts (step_counts),
    .buffer_dtr  (buffer_dtr),
    .wr_slot     (wr_slot),
    .wr_dir      (wr_dir),
    .wr_duration (wr_duration),
    .wr_rate     (wr_rate),
    .wr_accel    (wr_accel),
    .wr_field_en (wr_field_en),
    .wr_commit   (wr_commit),
    .divisor     (divisor),
    .enable      (enable),
    .brake       (brake),
    .reply_word  (reply_word)
  );

  move_buffer u_buffer (
    .CLK         (CLK),
    .resetn      (resetn),
    .wr_slot     (wr_slot),
    .wr_dir      (wr_dir),
    .wr_duration (wr_duration),
    .wr_rate     (wr_rate),
    .wr_accel    (wr_accel),
    .wr_field_en (wr_field_en),
    .wr_commit   (wr_commit),
    .rd_slot     (rd_slot),
    .slot_ready  (slot_ready),
    .rd_dir      (dir),
    .rd_duration (rd_duration),
    .rd_rate     (rd_rate),
    .rd_accel    (rd_accel)
  );

  move_sequencer u_sequencer (
    .CLK         (CLK),
    .resetn      (resetn),
    .divisor     (divisor),
    .slot_ready  (slot_ready),
    .rd_duration (rd_duration),
    .rd_slot     (rd_slot),
    .dda_tick    (dda_tick),
    .load_move   (load_move),
    .executing   (executing),
    .move_done   (move_done),
    .buffer_dtr  (buffer_dtr)
  );

  // One DDA per motor
  for (genvar i = 0; i < motor_count; i++) begin : g_axis
    dda_axis u_axis (
      .CLK        (CLK),
      .resetn     (resetn),
      .dda_tick   (dda_tick),
      .load_move  (load_move),
      .executing  (executing),
      .rate       (rd_rate[i]),
      .accel      (rd_accel[i]),
      .dir_bit    (dir[i]),
      .step_bit   (step[i]),
      .step_count (step_counts[i])
    );
  end

endmodule

// File: tests/stepper_ctrl_checker.sv
`timescale 1ns/1ps

module stepper_ctrl_checker (
  input  logic                   CLK,
  input  logic                   resetn,
  input  logic                   move_done,
  input  logic                   executing,
  input  stepper_pkg::axis_vec_t step,
  input  stepper_pkg::word_t     reply_word
);
  int fail_count = 0;

  // move_done is a single-cycle pulse
  done_pulse: assert property (@(posedge CLK) disable iff (resetn) move_done |=> !move_done)
    else begin
      fail_count++;
      $error("move_done stayed high for more than one cycle");
    end

  // Steps only come from ticks of a running move
  step_in_move: assert property (@(posedge CLK) disable iff (resetn) (step != '0) |-> executing)
    else begin
      fail_count++;
      $error("step pulse while the sequencer is not executing");
    end

  reply_after_reset: assert property (@(posedge CLK) $fell(resetn) |-> reply_word == '0)
    else begin
      fail_count++;
      $error("reply_word not zero after reset");
    end

endmodule

bind stepper_ctrl_top stepper_ctrl_checker chk0 (
  .CLK        (CLK),
  .resetn     (resetn),
  .move_done  (move_done),
  .executing  (executing),
  .step       (step),
  .reply_word (reply_word)
);

// File: tests/tb_monitor.sv
`timescale 1ns/1ps

module tb_monitor (
  input  logic                   CLK,
  input  logic                   resetn,
  input  stepper_pkg::word_t     word_in,
  input  logic                   word_strobe,
  input  stepper_pkg::word_t     reply_word,
  input  logic                   buffer_dtr,
  input  logic                   move_done,
  input  stepper_pkg::axis_vec_t step,
  input  stepper_pkg::axis_vec_t dir,
  input  stepper_pkg::axis_vec_t enable,
  input  stepper_pkg::axis_vec_t brake,
  input  int                     test_id,
  input  logic                   test_end,
  output int                     errors,
  output int                     checks
);
  import stepper_pkg::*;

  // Queued moves with motor_count rate and accel entries per move
  axis_vec_t q_dir [$];
  duration_t q_dur [$];
  rate_t q_rate [$];
  rate_t q_accel [$];

  logic strobe_q;
  logic compare_due;
  int stage;
  int word_idx;
  word_t held_word;
  axis_vec_t new_dir;
  duration_t new_dur;
  rate_t new_rate [motor_count];
  rate_t new_accel [motor_count];
  step_count_t snap [motor_count];
  step_count_t count [motor_count];
  int pulses [motor_count];
  logic [63:0] phase [motor_count];
  word_t exp_reply;
  axis_vec_t exp_enable;
  axis_vec_t exp_brake;
  divisor_t exp_divisor;
  int cycle;
  int start_cycle;
  int test_base;

  function automatic word_t extend(input step_count_t c);
    return {{32{c[31]}}, c};
  endfunction

  function automatic string test_name(input int id);
    case (id)
      1: return "api version";
      2: return "enable and brake";
      3: return "coordinated moves";
      4: return "move timing";
      5: return "back to back moves";
      6: return "step count replies";
      default: return "unnamed";
    endcase
  endfunction

  task automatic check_value(input string name, input word_t expected, input word_t actual);
    checks++;
    if (expected !== actual) begin
      errors++;
      $display("Error %s expected %h got %h at %0t", name, expected, actual, $time);
    end
  endtask

  task automatic report_event(input string msg);
    errors++;
    $display("%s at %0t", msg, $time);
  endtask

  // Decoder model for one accepted word
  task automatic apply_word(input word_t w);
    int axis;
    exp_reply = '0;
    if (word_idx == 0) begin
      case (w[63:56])
        cmd_coordinated_step: begin
          new_dir = w[motor_count-1:0];
          for (int n = 0; n < motor_count; n++) begin
            snap[n] = count[n];
          end
          word_idx = 1;
        end
        cmd_motor_enable: exp_enable = w[motor_count-1:0];
        cmd_motor_brake: exp_brake = w[motor_count-1:0];
        cmd_clk_divisor: exp_divisor = w[7:0];
        cmd_api_version: begin
          exp_reply = {32'd0, version_devel, version_major, version_minor, version_patch};
        end
        default: exp_reply = '0;
      endcase
    end else begin
      axis = (word_idx - 2) / 2;
      if (word_idx == 1) begin
        new_dur = w[31:0];
        exp_reply = extend(snap[0]);
      end else if (word_idx % 2 == 0) begin
        new_rate[axis] = w;
      end else begin
        new_accel[axis] = w;
        if (axis + 1 < motor_count) begin
          exp_reply = extend(snap[axis + 1]);
        end
      end
      word_idx++;
      if (word_idx == 2 + 2 * motor_count) begin
        // Move from an empty buffer starts timing at its commit
        if (q_dir.size() == 0) begin
          start_cycle = cycle;
        end
        q_dir.push_back(new_dir);
        q_dur.push_back(new_dur);
        for (int n = 0; n < motor_count; n++) begin
          q_rate.push_back(new_rate[n]);
          q_accel.push_back(new_accel[n]);
        end
        word_idx = 0;
      end
    end
  endtask

  // Accumulator model of the head move checked against counted pulses
  task automatic finish_move();
    logic [64:0] sum;
    logic [63:0] ph;
    rate_t vel;
    int expected_steps;
    int expected_cycles;
    int elapsed;
    int period;
    period = int'(exp_divisor) + 1;
    expected_cycles = int'(q_dur[0]) * period;
    elapsed = cycle - start_cycle;
    if (elapsed - expected_cycles > period || expected_cycles - elapsed > period) begin
      report_event($sformatf("Move took %0d cycles where about %0d were expected",
                             elapsed, expected_cycles));
    end
    check_value("dir", word_t'(q_dir[0]), word_t'(dir));
    for (int n = 0; n < motor_count; n++) begin
      ph = phase[n];
      vel = q_rate[n];
      expected_steps = 0;
      for (int t = 0; t < int'(q_dur[0]); t++) begin
        sum = {1'b0, ph} + {1'b0, vel};
        if (sum[64]) begin
          expected_steps++;
        end
        ph = sum[63:0];
        vel = vel + q_accel[n];
      end
      phase[n] = ph;
      check_value($sformatf("step[%0d] pulses", n), word_t'(expected_steps), word_t'(pulses[n]));
      pulses[n] = 0;
    end
    void'(q_dir.pop_front());
    void'(q_dur.pop_front());
    for (int n = 0; n < motor_count; n++) begin
      void'(q_rate.pop_front());
      void'(q_accel.pop_front());
    end
    // Queued move follows right away
    if (q_dir.size() > 0) begin
      start_cycle = cycle;
    end
  endtask

  always @(posedge CLK) begin
    if (resetn) begin
      strobe_q = 1'b0;
      compare_due = 1'b0;
      stage = 0;
      word_idx = 0;
      exp_reply = '0;
      exp_enable = '0;
      exp_brake = '0;
      exp_divisor = default_divisor;
      cycle = 0;
      start_cycle = 0;
      q_dir.delete();
      q_dur.delete();
      q_rate.delete();
      q_accel.delete();
      for (int n = 0; n < motor_count; n++) begin
        count[n] = '0;
        pulses[n] = 0;
        phase[n] = '0;
      end
    end else begin
      cycle++;
      // Outputs settle in the cycle after the decoder acts
      if (compare_due) begin
        check_value("reply_word", exp_reply, reply_word);
        check_value("enable", word_t'(exp_enable), word_t'(enable));
        check_value("brake", word_t'(exp_brake), word_t'(brake));
        check_value("buffer_dtr", word_t'(q_dir.size() < buffer_slots), word_t'(buffer_dtr));
        if (q_dir.size() > 0) begin
          check_value("dir", word_t'(q_dir[0]), word_t'(dir));
        end
        compare_due = 1'b0;
      end
      // Decoder acts two edges after the strobe is first seen high
      if (stage == 2) begin
        apply_word(held_word);
        compare_due = 1'b1;
        stage = 0;
      end else if (stage == 1) begin
        stage = 2;
      end
      if (word_strobe && !strobe_q) begin
        held_word = word_in;
        stage = 1;
      end
      strobe_q = word_strobe;
      if (q_dir.size() == 0) begin
        if (step != '0) begin
          report_event("Step pulse seen with no move in progress");
        end
      end else begin
        for (int n = 0; n < motor_count; n++) begin
          if (step[n]) begin
            pulses[n]++;
            count[n] = count[n] + (q_dir[0][n] ? 32'sd1 : -32'sd1);
          end
        end
      end
      if (move_done) begin
        if (q_dir.size() == 0) begin
          report_event("move_done pulsed with no move queued");
        end else begin
          finish_move();
        end
      end
      if (test_end) begin
        $display("Test %0d (%s) finished with %0d errors",
                 test_id, test_name(test_id), errors - test_base);
        test_base = errors;
      end
    end
  end

endmodule

// File: tests/tb_top.sv
`timescale 1ns/1ps

module tb_top;
  import stepper_pkg::*;

  logic CLK;
  logic resetn;
  word_t word_in;
  logic word_strobe;
  word_t reply_word;
  logic buffer_dtr;
  logic move_done;
  axis_vec_t step;
  axis_vec_t dir;
  axis_vec_t enable;
  axis_vec_t brake;

  int test_id;
  logic test_end;
  int mon_errors;
  int mon_checks;
  integer seed;
  int moves_sent;
  int moves_done;
  int tests_run;
  int total_errors;
  divisor_t div;

  stepper_ctrl_top dut0 (
    .CLK         (CLK),
    .resetn      (resetn),
    .word_in     (word_in),
    .word_strobe (word_strobe),
    .reply_word  (reply_word),
    .buffer_dtr  (buffer_dtr),
    .move_done   (move_done),
    .step        (step),
    .dir         (dir),
    .enable      (enable),
    .brake       (brake)
  );

  tb_monitor mon0 (
    .CLK         (CLK),
    .resetn      (resetn),
    .word_in     (word_in),
    .word_strobe (word_strobe),
    .reply_word  (reply_word),
    .buffer_dtr  (buffer_dtr),
    .move_done   (move_done),
    .step        (step),
    .dir         (dir),
    .enable      (enable),
    .brake       (brake),
    .test_id     (test_id),
    .test_end    (test_end),
    .errors      (mon_errors),
    .checks      (mon_checks)
  );

  always #4 CLK = ~CLK;

  always @(posedge CLK) begin
    if (resetn) begin
      moves_done <= 0;
    end else if (move_done) begin
      moves_done <= moves_done + 1;
    end
  end

  task automatic timeout_fail(input string what);
    $display("Timeout while waiting for %s", what);
    $display("SOME TESTS FAILED");
    $finish;
  endtask

  // Strobe high for 4 cycles then low for 4 while word_in holds until the next word
  task automatic send_word(input word_t w);
    @(negedge CLK);
    word_in = w;
    word_strobe = 1'b1;
    repeat (4) @(negedge CLK);
    word_strobe = 1'b0;
    repeat (4) @(negedge CLK);
  endtask

  task automatic wait_dtr();
    int n;
    n = 0;
    while (!buffer_dtr && n < 20000) begin
      @(negedge CLK);
      n++;
    end
    if (!buffer_dtr) begin
      timeout_fail("buffer_dtr");
    end
  endtask

  task automatic wait_moves(input int target);
    int n;
    n = 0;
    while (moves_done < target && n < 20000) begin
      @(negedge CLK);
      n++;
    end
    if (moves_done < target) begin
      timeout_fail("move_done");
    end
  endtask

  task automatic send_move(input duration_t dur);
    axis_vec_t d;
    rate_t r;
    rate_t a;
    d = axis_vec_t'($random(seed));
    wait_dtr();
    send_word({cmd_coordinated_step, {(56 - motor_count){1'b0}}, d});
    send_word({32'($random(seed)), dur});
    for (int n = 0; n < motor_count; n++) begin
      r = {1'b0, 31'($random(seed)), 32'($random(seed))};
      a = $random(seed);
      a = a <<< 24;
      send_word(r);
      send_word(a);
    end
    moves_sent++;
  endtask

  task automatic set_divisor(input divisor_t d);
    send_word({cmd_clk_divisor, 48'd0, d});
  endtask

  task automatic end_test(input int id);
    @(negedge CLK);
    test_id = id;
    test_end = 1'b1;
    @(negedge CLK);
    test_end = 1'b0;
    tests_run++;
  endtask

  initial begin
    CLK = 1'b0;
    resetn = 1'b1;
    word_in = '0;
    word_strobe = 1'b0;
    test_id = 0;
    test_end = 1'b0;
    seed = 32'h9f38_db41;
    moves_sent = 0;
    tests_run = 0;
    repeat (3) @(posedge CLK);
    @(negedge CLK);
    resetn = 1'b0;

    send_word({cmd_api_version, 56'd0});
    end_test(1);

    repeat (8) begin
      send_word({cmd_motor_enable, 24'($random(seed)), 32'($random(seed))});
      send_word({cmd_motor_brake, 24'($random(seed)), 32'($random(seed))});
    end
    end_test(2);

    // Default divisor
    repeat (3) begin
      send_move(duration_t'(1 + ($unsigned($random(seed)) % 12)));
      wait_moves(moves_sent);
    end
    end_test(3);

    repeat (3) begin
      div = divisor_t'(1 + ($unsigned($random(seed)) % 6));
      set_divisor(div);
      send_move(duration_t'(1 + ($unsigned($random(seed)) % 24)));
      wait_moves(moves_sent);
    end
    end_test(4);

    // Third move has to wait for the first to leave the buffer
    set_divisor(8'd3);
    send_move(duration_t'(40));
    send_move(duration_t'(8));
    send_move(duration_t'(5));
    wait_moves(moves_sent);
    end_test(5);

    send_move(duration_t'(1 + ($unsigned($random(seed)) % 16)));
    wait_moves(moves_sent);
    send_move(duration_t'(1 + ($unsigned($random(seed)) % 16)));
    wait_moves(moves_sent);
    end_test(6);

    repeat (4) @(negedge CLK);
    total_errors = mon_errors + dut0.chk0.fail_count;
    $display("Tests run %0d, checks %0d, errors %0d", tests_run, mon_checks, total_errors);
    if (total_errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

// File: stepper_ctrl.f
src/stepper_pkg.sv
src/dda_axis.sv
src/move_buffer.sv
src/move_sequencer.sv
src/command_decoder.sv
src/stepper_ctrl_top.sv
tests/stepper_ctrl_checker.sv
tests/tb_monitor.sv
tests/tb_top.sv

// File: Makefile
TOP := tb_top
FILELIST := stepper_ctrl.f

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -Wno-fatal --top-module $(TOP) -f $(FILELIST)

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-f $(FILELIST) -o sim_$(TOP)
	./obj_dir/sim_$(TOP) | tee sim.log
	grep -q "ALL TESTS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
